// File: logic/csr_map_pkg.sv
// CSR map for the machine-mode CSR unit
// Addresses, field positions and the fixed misa extension bits
`default_nettype none

package csr_map_pkg;

  typedef logic [11:0] csr_addr_t;

  // Machine-mode CSR addresses
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_misa     = 12'h301;
  localparam csr_addr_t addr_mie      = 12'h304;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mepc     = 12'h341;
  localparam csr_addr_t addr_mcause   = 12'h342;
  localparam csr_addr_t addr_mtval    = 12'h343;
  localparam csr_addr_t addr_mip      = 12'h344;

  // mstatus fields, MPP is two bits wide
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;
  localparam int mstatus_mpp  = 11;

  // Same positions in mip and mie
  localparam int bit_msi = 3;
  localparam int bit_mti = 7;
  localparam int bit_mei = 11;

  // Extensions I (bit 8) and U (bit 20)
  localparam logic [25:0] misa_low = 26'h010_0100;

endpackage

`default_nettype wire

// File: logic/trap_pkg.sv
// Trap definitions for the machine-mode CSR unit
// Privilege levels and mcause codes
`default_nettype none

package trap_pkg;

  typedef logic [1:0] priv_t;

  localparam priv_t priv_user    = 2'b00;
  localparam priv_t priv_machine = 2'b11;

  // Exception codes fit in four bits
  typedef logic [3:0] code_t;

  // Interrupt codes, reported with the mcause top bit set
  localparam code_t code_msi = 4'd3;
  localparam code_t code_mti = 4'd7;
  localparam code_t code_mei = 4'd11;

  // Synchronous exception codes
  localparam code_t code_illegal = 4'd2;
  localparam code_t code_ecall_u = 4'd8;
  localparam code_t code_ecall_m = 4'd11;

  // Fixed priority, highest first:
  // external, timer, software interrupt, then illegal instruction, then ecall

endpackage

`default_nettype wire

// File: logic/csr_bus_if.sv
// CSR access and trap event bundle shared by the CSR blocks
`default_nettype none

interface csr_bus_if #(
  parameter int xlen = 32
);

  logic                   wr_en;
  csr_map_pkg::csr_addr_t addr;
  logic [xlen-1:0]        wr_data;
  logic                   trap;
  logic [xlen-1:0]        cause;
  // mret already masked by trap
  logic                   take_mret;

  modport arbiter (
    input  wr_en, addr, wr_data,
    output trap, cause, take_mret
  );

  modport regs (
    input wr_en, addr, wr_data, trap, cause, take_mret
  );

  modport reader (
    input addr
  );

endinterface

`default_nettype wire

// File: logic/csr_config_regs.sv
// Trap configuration registers
// Holds mtvec, the machine enable bits of mie and mscratch
`default_nettype none

module csr_config_regs #(
  parameter int              xlen        = 32,
  parameter logic [xlen-1:0] mtvec_reset = '0
) (
  input  wire             clock,
  input  wire             reset,
  csr_bus_if.regs         bus,
  output logic [xlen-1:0] mtvec,
  output logic [2:0]      mie_bits,
  output logic [xlen-1:0] mscratch
);

  logic            wr_ok;
  logic [xlen-3:0] mtvec_base;
  logic            mtvec_mode;

  // Writes are dropped in a trap cycle
  assign wr_ok = bus.wr_en && !bus.trap;

  // Bit 1 is reserved and reads zero
  assign mtvec = {mtvec_base, 1'b0, mtvec_mode};

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec_base <= mtvec_reset[xlen-1:2];
      mtvec_mode <= mtvec_reset[0];
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mtvec) begin
      mtvec_base <= bus.wr_data[xlen-1:2];
      mtvec_mode <= bus.wr_data[0];
    end
  end

  // Only MEIE, MTIE and MSIE exist
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mie_bits <= 3'b000;
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mie) begin
      mie_bits <= {bus.wr_data[csr_map_pkg::bit_mei],
                   bus.wr_data[csr_map_pkg::bit_mti],
                   bus.wr_data[csr_map_pkg::bit_msi]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mscratch <= '0;
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mscratch) begin
      mscratch <= bus.wr_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/trap_state_regs.sv
// Trap state registers
// mstatus fields, mepc, mcause, mtval and the current privilege level
`default_nettype none

module trap_state_regs #(
  parameter int xlen = 32
) (
  input  wire              clock,
  input  wire              reset,
  csr_bus_if.regs          bus,
  input  wire [xlen-1:0]   pc,
  input  wire [31:0]       instruction,
  output trap_pkg::priv_t  priv,
  output logic             mstatus_mie,
  output logic             mstatus_mpie,
  output trap_pkg::priv_t  mpp,
  output logic [xlen-1:0]  mepc,
  output logic [xlen-1:0]  mcause,
  output logic [xlen-1:0]  mtval
);

  logic            wr_ok;
  logic            cause_illegal;
  trap_pkg::priv_t mpp_wr;

  // mcause is WLRL, only implemented codes are accepted
  function automatic logic legal_cause(input logic [xlen-1:0] value);
    logic [xlen-2:0] code;
    code = value[xlen-2:0];
    if (value[xlen-1]) begin
      legal_cause = (code == trap_pkg::code_msi) || (code == trap_pkg::code_mti) ||
                    (code == trap_pkg::code_mei);
    end else begin
      legal_cause = (code == trap_pkg::code_illegal) ||
                    (code == trap_pkg::code_ecall_u) ||
                    (code == trap_pkg::code_ecall_m);
    end
  endfunction

  assign wr_ok         = bus.wr_en && !bus.trap;
  assign cause_illegal = (bus.cause == {{(xlen-4){1'b0}}, trap_pkg::code_illegal});
  assign mpp_wr        = bus.wr_data[csr_map_pkg::mstatus_mpp +: 2];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mpp          <= trap_pkg::priv_user;
    end else if (bus.trap) begin
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
      mpp          <= priv;
    end else if (bus.take_mret) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
      mpp          <= trap_pkg::priv_user;
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mstatus) begin
      mstatus_mie  <= bus.wr_data[csr_map_pkg::mstatus_mie];
      mstatus_mpie <= bus.wr_data[csr_map_pkg::mstatus_mpie];
      // No supervisor level, so 1 and 2 are not stored
      if (mpp_wr == trap_pkg::priv_user || mpp_wr == trap_pkg::priv_machine) begin
        mpp <= mpp_wr;
      end
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      priv <= trap_pkg::priv_machine;
    end else if (bus.trap) begin
      priv <= trap_pkg::priv_machine;
    end else if (bus.take_mret) begin
      priv <= mpp;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc <= '0;
    end else if (bus.trap) begin
      mepc <= pc;
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mepc) begin
      mepc <= {bus.wr_data[xlen-1:2], 2'b00};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mcause <= '0;
    end else if (bus.trap) begin
      mcause <= bus.cause;
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mcause && legal_cause(bus.wr_data)) begin
      mcause <= bus.wr_data;
    end
  end

  // Other traps leave mtval as it was
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtval <= '0;
    end else if (bus.trap) begin
      if (cause_illegal) begin
        mtval <= xlen'(instruction);
      end
    end else if (wr_ok && bus.addr == csr_map_pkg::addr_mtval) begin
      mtval <= bus.wr_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/trap_arbiter.sv
// Trap arbiter
// Evaluates pending interrupts and exceptions, picks the cause and the trap target
`default_nettype none

module trap_arbiter #(
  parameter int xlen = 32
) (
  csr_bus_if.arbiter          bus,
  input  wire                 msip,
  input  wire                 external_interrupt,
  input  wire [63:0]          mtime,
  input  wire [63:0]          mtimecmp,
  input  wire                 illegal_instruction,
  input  wire                 ecall,
  input  wire                 mret,
  input  wire trap_pkg::priv_t priv,
  input  wire                 mstatus_mie,
  input  wire [xlen-1:0]      mtvec,
  input  wire [2:0]           mie_bits,
  output logic [xlen-1:0]     trap_addr,
  output logic [2:0]          mip_bits
);

  logic              irq_enable;
  logic [2:0]        irq_fire;
  logic              is_irq;
  logic              trap_now;
  trap_pkg::code_t   code;
  logic [xlen-1:0]   base;

  // Bit order is MEI, MTI, MSI
  assign mip_bits = {external_interrupt, mtime >= mtimecmp, msip};

  // User mode is always interruptible, machine mode only with MIE
  assign irq_enable = (priv == trap_pkg::priv_user) || mstatus_mie;
  assign irq_fire   = mip_bits & mie_bits & {3{irq_enable}};
  assign is_irq     = |irq_fire;

  always_comb begin
    if (irq_fire[2]) begin
      code = trap_pkg::code_mei;
    end else if (irq_fire[1]) begin
      code = trap_pkg::code_mti;
    end else if (irq_fire[0]) begin
      code = trap_pkg::code_msi;
    end else if (illegal_instruction) begin
      code = trap_pkg::code_illegal;
    end else if (ecall) begin
      // ecall code tracks the caller's level
      if (priv == trap_pkg::priv_machine) begin
        code = trap_pkg::code_ecall_m;
      end else begin
        code = trap_pkg::code_ecall_u;
      end
    end else begin
      code = '0;
    end
  end

  // Exceptions are never masked
  assign trap_now = is_irq || illegal_instruction || ecall;

  assign bus.trap      = trap_now;
  assign bus.cause     = {is_irq, {(xlen-5){1'b0}}, code};
  assign bus.take_mret = mret && !trap_now;

  assign base = {mtvec[xlen-1:2], 2'b00};

  // Vectored mode offsets interrupts by four times the code
  assign trap_addr = (mtvec[0] && is_irq) ? base + {code, 2'b00} : base;

endmodule

`default_nettype wire

// File: logic/csr_read_mux.sv
// CSR read path
// Builds the readable CSR words and selects one by address
`default_nettype none

module csr_read_mux #(
  parameter int xlen = 32
) (
  csr_bus_if.reader           bus,
  input  wire                 mstatus_mie,
  input  wire                 mstatus_mpie,
  input  wire trap_pkg::priv_t mpp,
  input  wire [xlen-1:0]      mtvec,
  input  wire [2:0]           mie_bits,
  input  wire [xlen-1:0]      mscratch,
  input  wire [xlen-1:0]      mepc,
  input  wire [xlen-1:0]      mcause,
  input  wire [xlen-1:0]      mtval,
  input  wire [2:0]           mip_bits,
  output logic [xlen-1:0]     rd_data
);

  logic [xlen-1:0] misa;
  logic [xlen-1:0] mstatus;

  // Spreads MEI, MTI, MSI to their mie/mip positions
  function automatic logic [xlen-1:0] irq_word(input logic [2:0] bits);
    logic [xlen-1:0] word;
    word = '0;
    word[csr_map_pkg::bit_mei] = bits[2];
    word[csr_map_pkg::bit_mti] = bits[1];
    word[csr_map_pkg::bit_msi] = bits[0];
    return word;
  endfunction

  always_comb begin
    // MXL is 1 for RV32, 2 for RV64
    misa = '0;
    misa[xlen-1 -: 2] = 2'(xlen / 32);
    misa[25:0] = csr_map_pkg::misa_low;

    mstatus = '0;
    mstatus[csr_map_pkg::mstatus_mie]       = mstatus_mie;
    mstatus[csr_map_pkg::mstatus_mpie]      = mstatus_mpie;
    mstatus[csr_map_pkg::mstatus_mpp +: 2]  = mpp;
  end

  always_comb begin
    case (bus.addr)
      csr_map_pkg::addr_mstatus:  rd_data = mstatus;
      csr_map_pkg::addr_misa:     rd_data = misa;
      csr_map_pkg::addr_mie:      rd_data = irq_word(mie_bits);
      csr_map_pkg::addr_mtvec:    rd_data = mtvec;
      csr_map_pkg::addr_mscratch: rd_data = mscratch;
      csr_map_pkg::addr_mepc:     rd_data = mepc;
      csr_map_pkg::addr_mcause:   rd_data = mcause;
      csr_map_pkg::addr_mtval:    rd_data = mtval;
      csr_map_pkg::addr_mip:      rd_data = irq_word(mip_bits);
      default:                    rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/csr_top.sv
// Machine-mode CSR unit with trap handling for an M/U core
`default_nettype none

module csr_top #(
  parameter int              xlen        = 32,
  parameter logic [xlen-1:0] mtvec_reset = xlen'(1000 << 2)
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         wr_en,
  input  wire csr_map_pkg::csr_addr_t addr,
  input  wire [xlen-1:0]              wr_data,
  input  wire [xlen-1:0]              pc,
  input  wire [31:0]                  instruction,
  input  wire                         msip,
  input  wire                         external_interrupt,
  input  wire [63:0]                  mtime,
  input  wire [63:0]                  mtimecmp,
  input  wire                         illegal_instruction,
  input  wire                         ecall,
  input  wire                         mret,
  output logic [xlen-1:0]             rd_data,
  output logic [xlen-1:0]             mepc,
  output logic [xlen-1:0]             trap_addr,
  output logic                        trap,
  output trap_pkg::priv_t             privilege_mode
);

  trap_pkg::priv_t priv;
  trap_pkg::priv_t mpp;
  logic            mstatus_mie;
  logic            mstatus_mpie;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [2:0]      mie_bits;
  logic [2:0]      mip_bits;

  csr_bus_if #(.xlen(xlen)) bus ();

  assign bus.wr_en   = wr_en;
  assign bus.addr    = addr;
  assign bus.wr_data = wr_data;

  assign trap           = bus.trap;
  assign privilege_mode = priv;

  csr_config_regs #(.xlen(xlen), .mtvec_reset(mtvec_reset)) config_regs_i (
    .clock(clock), .reset(reset), .bus(bus.regs),
    .mtvec(mtvec), .mie_bits(mie_bits), .mscratch(mscratch)
  );

  trap_state_regs #(.xlen(xlen)) state_regs_i (
    .clock(clock), .reset(reset), .bus(bus.regs),
    .pc(pc), .instruction(instruction),
    .priv(priv), .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie), .mpp(mpp),
    .mepc(mepc), .mcause(mcause), .mtval(mtval)
  );

  trap_arbiter #(.xlen(xlen)) arbiter_i (
    .bus(bus.arbiter), .msip(msip), .external_interrupt(external_interrupt),
    .mtime(mtime), .mtimecmp(mtimecmp),
    .illegal_instruction(illegal_instruction), .ecall(ecall), .mret(mret),
    .priv(priv), .mstatus_mie(mstatus_mie), .mtvec(mtvec), .mie_bits(mie_bits),
    .trap_addr(trap_addr), .mip_bits(mip_bits)
  );

  csr_read_mux #(.xlen(xlen)) read_mux_i (
    .bus(bus.reader), .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie), .mpp(mpp),
    .mtvec(mtvec), .mie_bits(mie_bits), .mscratch(mscratch), .mepc(mepc),
    .mcause(mcause), .mtval(mtval), .mip_bits(mip_bits), .rd_data(rd_data)
  );

endmodule

`default_nettype wire

// File: verif/csr_checker.sv
// Reference model of the machine-mode CSR unit
// Predicts trap, trap_addr, rd_data, mepc and privilege each cycle and compares
`default_nettype none

module csr_checker #(
  parameter int              xlen        = 32,
  parameter logic [xlen-1:0] mtvec_reset = '0
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         wr_en,
  input  wire csr_map_pkg::csr_addr_t addr,
  input  wire [xlen-1:0]              wr_data,
  input  wire [xlen-1:0]              pc,
  input  wire [31:0]                  instruction,
  input  wire                         msip,
  input  wire                         external_interrupt,
  input  wire [63:0]                  mtime,
  input  wire [63:0]                  mtimecmp,
  input  wire                         illegal_instruction,
  input  wire                         ecall,
  input  wire                         mret,
  input  wire [xlen-1:0]              rd_data,
  input  wire [xlen-1:0]              mepc,
  input  wire [xlen-1:0]              trap_addr,
  input  wire                         trap,
  input  wire trap_pkg::priv_t        privilege_mode,
  output int                          check_count,
  output int                          error_count
);

  // Model state
  trap_pkg::priv_t model_priv;
  trap_pkg::priv_t model_mpp;
  logic            model_mie;
  logic            model_mpie;
  logic [xlen-1:0] model_mtvec;
  logic [2:0]      model_enables;
  logic [xlen-1:0] model_mscratch;
  logic [xlen-1:0] model_mepc;
  logic [xlen-1:0] model_mcause;
  logic [xlen-1:0] model_mtval;
  logic [xlen-1:0] misa_value;

  // Per-cycle predictions in MEI, MTI, MSI bit order
  logic [2:0]      pending;
  logic [2:0]      fire;
  logic            exp_irq;
  logic            exp_trap;
  logic [3:0]      exp_code;
  logic [xlen-1:0] exp_cause;
  logic [xlen-1:0] exp_addr;

  function automatic string csr_name(input csr_map_pkg::csr_addr_t a);
    case (a)
      csr_map_pkg::addr_mstatus:  return "read mstatus";
      csr_map_pkg::addr_misa:     return "read misa";
      csr_map_pkg::addr_mie:      return "read mie";
      csr_map_pkg::addr_mtvec:    return "read mtvec";
      csr_map_pkg::addr_mscratch: return "read mscratch";
      csr_map_pkg::addr_mepc:     return "read mepc";
      csr_map_pkg::addr_mcause:   return "read mcause";
      csr_map_pkg::addr_mtval:    return "read mtval";
      csr_map_pkg::addr_mip:      return "read mip";
      default:                    return "read unmapped";
    endcase
  endfunction

  function automatic logic [xlen-1:0] expected_read(input csr_map_pkg::csr_addr_t a,
                                                    input logic [2:0] irq_pending);
    logic [xlen-1:0] word;
    word = '0;
    case (a)
      csr_map_pkg::addr_mstatus: begin
        word[csr_map_pkg::mstatus_mie]      = model_mie;
        word[csr_map_pkg::mstatus_mpie]     = model_mpie;
        word[csr_map_pkg::mstatus_mpp +: 2] = model_mpp;
      end
      csr_map_pkg::addr_misa:     word = misa_value;
      csr_map_pkg::addr_mie: begin
        word[csr_map_pkg::bit_mei] = model_enables[2];
        word[csr_map_pkg::bit_mti] = model_enables[1];
        word[csr_map_pkg::bit_msi] = model_enables[0];
      end
      csr_map_pkg::addr_mtvec:    word = model_mtvec;
      csr_map_pkg::addr_mscratch: word = model_mscratch;
      csr_map_pkg::addr_mepc:     word = model_mepc;
      csr_map_pkg::addr_mcause:   word = model_mcause;
      csr_map_pkg::addr_mtval:    word = model_mtval;
      csr_map_pkg::addr_mip: begin
        word[csr_map_pkg::bit_mei] = irq_pending[2];
        word[csr_map_pkg::bit_mti] = irq_pending[1];
        word[csr_map_pkg::bit_msi] = irq_pending[0];
      end
      default: word = '0;
    endcase
    return word;
  endfunction

  // Accepted mcause values are interrupts 3, 7, 11 and exceptions 2, 8, 11
  function automatic logic legal_mcause(input logic [xlen-1:0] value);
    logic [3:0] low;
    low = value[3:0];
    if (value[xlen-2:4] != '0) begin
      return 1'b0;
    end
    if (value[xlen-1]) begin
      return low == trap_pkg::code_msi || low == trap_pkg::code_mti ||
             low == trap_pkg::code_mei;
    end
    return low == trap_pkg::code_illegal || low == trap_pkg::code_ecall_u ||
           low == trap_pkg::code_ecall_m;
  endfunction

  task automatic compare_word(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    check_count = check_count + 1;
    if (expected !== actual) begin
      error_count = error_count + 1;
      $display("** Error %s: expected %0h, actual %0h at time %0t",
               name, expected, actual, $time);
    end
  endtask

  task automatic reset_state();
    model_priv     = trap_pkg::priv_machine;
    model_mpp      = trap_pkg::priv_user;
    model_mie      = 1'b0;
    model_mpie     = 1'b0;
    model_mtvec    = mtvec_reset;
    model_enables  = 3'b000;
    model_mscratch = '0;
    model_mepc     = '0;
    model_mcause   = '0;
    model_mtval    = '0;
    // MXL in the top two bits, then extensions I (bit 8) and U (bit 20)
    misa_value                = '0;
    misa_value[xlen-1 -: 2]   = (xlen == 64) ? 2'd2 : 2'd1;
    misa_value[8]             = 1'b1;
    misa_value[20]            = 1'b1;
  endtask

  task automatic advance_state();
    trap_pkg::priv_t mpp_value;
    mpp_value = wr_data[csr_map_pkg::mstatus_mpp +: 2];
    if (exp_trap) begin
      model_mpie   = model_mie;
      model_mie    = 1'b0;
      model_mpp    = model_priv;
      model_priv   = trap_pkg::priv_machine;
      model_mepc   = pc;
      model_mcause = exp_cause;
      if (!exp_irq && exp_code == trap_pkg::code_illegal) begin
        model_mtval = xlen'(instruction);
      end
    end else begin
      if (mret) begin
        model_mie  = model_mpie;
        model_mpie = 1'b1;
        model_priv = model_mpp;
        model_mpp  = trap_pkg::priv_user;
      end
      if (wr_en) begin
        case (addr)
          csr_map_pkg::addr_mstatus: begin
            model_mie  = wr_data[csr_map_pkg::mstatus_mie];
            model_mpie = wr_data[csr_map_pkg::mstatus_mpie];
            if (mpp_value == trap_pkg::priv_user || mpp_value == trap_pkg::priv_machine) begin
              model_mpp = mpp_value;
            end
          end
          csr_map_pkg::addr_mie: begin
            model_enables = {wr_data[csr_map_pkg::bit_mei], wr_data[csr_map_pkg::bit_mti],
                             wr_data[csr_map_pkg::bit_msi]};
          end
          csr_map_pkg::addr_mtvec:    model_mtvec = wr_data & ~xlen'(2);
          csr_map_pkg::addr_mscratch: model_mscratch = wr_data;
          csr_map_pkg::addr_mepc:     model_mepc = wr_data & ~xlen'(3);
          csr_map_pkg::addr_mcause: begin
            if (legal_mcause(wr_data)) begin
              model_mcause = wr_data;
            end
          end
          csr_map_pkg::addr_mtval:    model_mtval = wr_data;
          // misa and mip are read-only
          default: ;
        endcase
      end
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      reset_state();
      check_count = 0;
      error_count = 0;
    end else begin
      pending = {external_interrupt, mtime >= mtimecmp, msip};
      fire    = pending & model_enables;
      // Machine mode masks interrupts unless MIE is set
      if (model_priv != trap_pkg::priv_user && !model_mie) begin
        fire = 3'b000;
      end
      exp_irq = |fire;
      if (fire[2]) begin
        exp_code = trap_pkg::code_mei;
      end else if (fire[1]) begin
        exp_code = trap_pkg::code_mti;
      end else if (fire[0]) begin
        exp_code = trap_pkg::code_msi;
      end else if (illegal_instruction) begin
        exp_code = trap_pkg::code_illegal;
      end else if (ecall) begin
        exp_code = (model_priv == trap_pkg::priv_machine) ? trap_pkg::code_ecall_m
                                                          : trap_pkg::code_ecall_u;
      end else begin
        exp_code = 4'd0;
      end
      exp_trap              = exp_irq || illegal_instruction || ecall;
      exp_cause             = xlen'(exp_code);
      exp_cause[xlen-1]     = exp_irq;
      exp_addr              = {model_mtvec[xlen-1:2], 2'b00};
      if (exp_irq && model_mtvec[0]) begin
        exp_addr = exp_addr + (xlen'(exp_code) << 2);
      end

      compare_word("trap", 64'(exp_trap), 64'(trap));
      compare_word("trap_addr", 64'(exp_addr), 64'(trap_addr));
      compare_word(csr_name(addr), 64'(expected_read(addr, pending)), 64'(rd_data));
      compare_word("mepc", 64'(model_mepc), 64'(mepc));
      compare_word("privilege_mode", 64'(model_priv), 64'(privilege_mode));
      advance_state();
    end
  end

endmodule

`default_nettype wire

// File: verif/csr_tb.sv
// Testbench for the machine-mode CSR unit
// LFSR-driven CSR, trap and mret traffic, checked by csr_checker
`default_nettype none

module csr_tb;

  localparam int              xlen          = 32;
  localparam logic [xlen-1:0] mtvec_reset   = xlen'(1000 << 2);
  localparam int              random_cycles = 2000;
  // Reset, directed reads and drain fit well inside the margin
  localparam int              cycle_limit   = random_cycles + random_cycles / 10;
  localparam logic [31:0]     seed          = 32'h7cb5_5e01;

  logic                   clock;
  logic                   reset;
  logic                   wr_en;
  csr_map_pkg::csr_addr_t addr;
  logic [xlen-1:0]        wr_data;
  logic [xlen-1:0]        pc;
  logic [31:0]            instruction;
  logic                   msip;
  logic                   external_interrupt;
  logic [63:0]            mtime;
  logic [63:0]            mtimecmp;
  logic                   illegal_instruction;
  logic                   ecall;
  logic                   mret;
  logic [xlen-1:0]        rd_data;
  logic [xlen-1:0]        mepc;
  logic [xlen-1:0]        trap_addr;
  logic                   trap;
  trap_pkg::priv_t        privilege_mode;
  logic [31:0]            lfsr_state;
  int                     cycle_count;
  int                     check_count;
  int                     error_count;

  csr_top #(.xlen(xlen), .mtvec_reset(mtvec_reset)) dut_i (
    .clock(clock), .reset(reset), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
    .pc(pc), .instruction(instruction), .msip(msip),
    .external_interrupt(external_interrupt), .mtime(mtime), .mtimecmp(mtimecmp),
    .illegal_instruction(illegal_instruction), .ecall(ecall), .mret(mret),
    .rd_data(rd_data), .mepc(mepc), .trap_addr(trap_addr), .trap(trap),
    .privilege_mode(privilege_mode)
  );

  csr_checker #(.xlen(xlen), .mtvec_reset(mtvec_reset)) checker_i (.*);

  // Right-shift Galois form, taps 32, 31, 29, 1
  function automatic logic [31:0] galois_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'hd000_0001;
    end
    return state >> 1;
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  // Index 9 and above is an unmapped address
  function automatic csr_map_pkg::csr_addr_t listed_addr(input logic [31:0] index);
    case (index)
      0:       return csr_map_pkg::addr_mstatus;
      1:       return csr_map_pkg::addr_misa;
      2:       return csr_map_pkg::addr_mie;
      3:       return csr_map_pkg::addr_mtvec;
      4:       return csr_map_pkg::addr_mscratch;
      5:       return csr_map_pkg::addr_mepc;
      6:       return csr_map_pkg::addr_mcause;
      7:       return csr_map_pkg::addr_mtval;
      8:       return csr_map_pkg::addr_mip;
      default: return 12'h7c0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] legal_mcause_value(input logic [2:0] index);
    case (index)
      0:       return {1'b1, {(xlen-5){1'b0}}, trap_pkg::code_msi};
      1:       return {1'b1, {(xlen-5){1'b0}}, trap_pkg::code_mti};
      2:       return {1'b1, {(xlen-5){1'b0}}, trap_pkg::code_mei};
      3:       return xlen'(trap_pkg::code_illegal);
      4:       return xlen'(trap_pkg::code_ecall_u);
      default: return xlen'(trap_pkg::code_ecall_m);
    endcase
  endfunction

  task automatic quiet_inputs();
    wr_en               = 1'b0;
    addr                = csr_map_pkg::addr_mstatus;
    wr_data             = '0;
    pc                  = '0;
    instruction         = '0;
    msip                = 1'b0;
    external_interrupt  = 1'b0;
    mtime               = '0;
    // Keep the timer below its compare value
    mtimecmp            = '1;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
  endtask

  task automatic drive_write();
    logic [31:0] bits;
    wr_en = 1'b1;
    take_bits(4, bits);
    addr = listed_addr(bits % 9);
    take_bits(32, bits);
    wr_data = bits;
    if (addr == csr_map_pkg::addr_mcause) begin
      take_bits(3, bits);
      if (bits < 6) begin
        wr_data = legal_mcause_value(bits[2:0]);
      end
    end
  endtask

  // Weights out of 16: write 6, read 3, exception 2, mret 2, interrupt inputs 3
  task automatic drive_random_cycle();
    logic [31:0] pick;
    logic [31:0] bits;
    take_bits(4, pick);
    wr_en               = 1'b0;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
    take_bits(32, bits);
    pc = {bits[31:2], 2'b00};
    take_bits(32, bits);
    instruction = bits;
    take_bits(4, bits);
    addr = listed_addr(bits % 10);
    if (pick < 6) begin
      drive_write();
    end else if (pick >= 9 && pick < 11) begin
      take_bits(2, bits);
      illegal_instruction = (bits != 1);
      ecall               = (bits == 1) || (bits == 2);
      // A write in the trap cycle must be dropped
      take_bits(1, bits);
      if (bits[0]) begin
        drive_write();
      end
    end else if (pick >= 11 && pick < 13) begin
      mret = 1'b1;
    end else if (pick >= 13) begin
      take_bits(2, bits);
      msip = &bits[1:0];
      take_bits(2, bits);
      external_interrupt = &bits[1:0];
      take_bits(9, bits);
      mtime = {23'd0, bits[8], 32'd0, bits[7:0]};
      take_bits(10, bits);
      mtimecmp = {23'd0, bits[9], 31'd0, bits[8:0]};
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    cycle_count = 0;
    lfsr_state  = seed;
    reset       = 1'b1;
    quiet_inputs();
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // Reset values of misa, mtvec and mstatus
    addr = csr_map_pkg::addr_misa;
    @(negedge clock);
    addr = csr_map_pkg::addr_mtvec;
    @(negedge clock);
    addr = csr_map_pkg::addr_mstatus;
    repeat (random_cycles) begin
      @(negedge clock);
      drive_random_cycle();
    end
    @(negedge clock);
    quiet_inputs();
    @(negedge clock);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
logic/csr_map_pkg.sv
logic/trap_pkg.sv
logic/csr_bus_if.sv
logic/csr_config_regs.sv
logic/trap_state_regs.sv
logic/trap_arbiter.sv
logic/csr_read_mux.sv
logic/csr_top.sv
verif/csr_checker.sv
verif/csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CSR unit testbench with Verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f files.f --top-module csr_tb -o csr_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csr_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
exit 0
